// File: Makefile
# Verilator build and run of the TMR wrapper testbench

TOP := hmr_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: logic/hmr_input_fanout.sv
/*
 * Input fan-out: steers system inputs to the cores, broadcasting
 * the master core's input to the whole group while it is in TMR
 */
`timescale 1ns/100ps
`include "hmr_params.svh"

module hmr_input_fanout import hmr_pkg::*; (
  input  core_data_t       sys_inputs_i  [`HMR_NUM_CORES],
  tmr_grp_if.fanout        grp           [`HMR_NUM_GROUPS],
  output core_data_t       core_inputs_o [`HMR_NUM_CORES]
);

  for (genvar c = 0; c < `HMR_NUM_CORES; c++) begin : gen_core_inputs
    // Groups are sequential, the first core of a group is its master
    localparam int unsigned GrpIdx    = c / `HMR_GRP_SIZE;
    localparam int unsigned MasterIdx = GrpIdx * `HMR_GRP_SIZE;

    logic core_in_tmr;

    assign core_in_tmr = grp[GrpIdx].in_tmr;

    // Master input goes to all three cores in TMR, own input otherwise
    assign core_inputs_o[c] = core_in_tmr ? sys_inputs_i[MasterIdx] : sys_inputs_i[c];
  end

endmodule

// File: logic/hmr_output_select.sv
/*
 * Output select: system outputs from voted or raw core words,
 * per-core error and setback flags, per-group failure
 */
`timescale 1ns/100ps
`include "hmr_params.svh"

module hmr_output_select import hmr_pkg::*; (
  input  core_data_t                 core_outputs_i [`HMR_NUM_CORES],
  tmr_grp_if.select                  grp            [`HMR_NUM_GROUPS],
  output core_data_t                 sys_outputs_o  [`HMR_NUM_CORES],
  output logic [`HMR_NUM_GROUPS-1:0] tmr_failure_o,
  output logic [`HMR_NUM_CORES-1:0]  tmr_error_o,
  output logic [`HMR_NUM_CORES-1:0]  core_setback_o
);

  for (genvar g = 0; g < `HMR_NUM_GROUPS; g++) begin : gen_grp_flags
    // Failure only means something while the group votes
    assign tmr_failure_o[g] = grp[g].in_tmr & grp[g].failure;
  end

  for (genvar c = 0; c < `HMR_NUM_CORES; c++) begin : gen_core_outputs
    localparam int unsigned GrpIdx = c / `HMR_GRP_SIZE;
    localparam int unsigned Offset = c % `HMR_GRP_SIZE;

    logic       core_in_tmr;
    core_data_t tmr_word;

    assign core_in_tmr = grp[GrpIdx].in_tmr;

    // Master port carries the vote, the other ports of the group are silenced
    if (Offset == 0) begin : gen_master
      assign tmr_word = grp[GrpIdx].voted;
    end else begin : gen_follower
      assign tmr_word = '0;
    end

    assign sys_outputs_o[c] = core_in_tmr ? tmr_word : core_outputs_i[c];

    // Spread the group error vector to core positions
    assign tmr_error_o[c] = core_in_tmr & grp[GrpIdx].error_cba[Offset];

    // Master keeps running on TMR entry, the other two are set back
    if (Offset == 0) begin : gen_master_setback
      assign core_setback_o[c] = 1'b0;
    end else begin : gen_follower_setback
      assign core_setback_o[c] = grp[GrpIdx].setback;
    end
  end

endmodule

// File: logic/hmr_params.svh
/*
 * Sizing macros for the TMR wrapper: core count, group size,
 * derived group count, core word width and mismatch counter width
 */
`ifndef HMR_PARAMS_SVH
`define HMR_PARAMS_SVH

`define HMR_NUM_CORES  6
`define HMR_GRP_SIZE   3
`define HMR_NUM_GROUPS (`HMR_NUM_CORES / `HMR_GRP_SIZE)
`define HMR_DATA_WIDTH 32
// Kept small so the counters can saturate in simulation
`define HMR_CNT_WIDTH  4

`endif

// File: logic/hmr_pkg.sv
/*
 * Shared types of the TMR wrapper: core word, per-group error
 * vector, mismatch count and the group mode/resynch state enum
 */
`include "hmr_params.svh"

package hmr_pkg;

  // One core's input or output word
  typedef logic [`HMR_DATA_WIDTH-1:0] core_data_t;

  // Disagreement flags, bit n belongs to core n of the group
  typedef logic [`HMR_GRP_SIZE-1:0] grp_err_t;

  // Saturating per-core mismatch count
  typedef logic [`HMR_CNT_WIDTH-1:0] mismatch_cnt_t;

  // Group state
  // TMR_INDEP   cores run independently
  // TMR_RUN     cores locked and voted
  // TMR_RESYNCH single mismatch seen, waiting for the cores to resync
  typedef enum logic [1:0] {
    TMR_INDEP,
    TMR_RUN,
    TMR_RESYNCH
  } tmr_state_e;

endpackage

// File: logic/hmr_tmr_group.sv
/*
 * One TMR group: bitwise majority voter with per-core disagreement
 * flags, mode/resynch FSM with setback pulse and saturating counters
 */
`timescale 1ns/100ps
`include "hmr_params.svh"

module hmr_tmr_group import hmr_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          tmr_enable_i,
  input  logic          tmr_enable_we_i,
  input  logic          tmr_cores_synch_i,
  input  core_data_t    core_outputs_i [`HMR_GRP_SIZE],
  output mismatch_cnt_t mismatch_cnt_o [`HMR_GRP_SIZE],
  output logic          tmr_resynch_req_o,
  tmr_grp_if.group      grp
);

  core_data_t    voted;
  grp_err_t      error_cba;
  logic          failure;
  logic          single_mismatch;
  logic          in_tmr;

  tmr_state_e    state_q;
  tmr_state_e    state_d;
  logic          setback_q;
  mismatch_cnt_t cnt_q [`HMR_GRP_SIZE];

  // Majority voter

  // Bitwise 2-of-3 majority
  assign voted = (core_outputs_i[0] & core_outputs_i[1]) |
                 (core_outputs_i[0] & core_outputs_i[2]) |
                 (core_outputs_i[1] & core_outputs_i[2]);

  // A core disagrees when its word differs from the majority
  always_comb begin : proc_error_cba
    for (int i = 0; i < `HMR_GRP_SIZE; i++) begin
      error_cba[i] = (core_outputs_i[i] != voted);
    end
  end

  // No majority at all when every pair differs
  assign failure = (core_outputs_i[0] != core_outputs_i[1]) &&
                   (core_outputs_i[0] != core_outputs_i[2]) &&
                   (core_outputs_i[1] != core_outputs_i[2]);

  // One core out of line, the other two still agree
  assign single_mismatch = (|error_cba) && !failure;

  // Mode and resynch FSM

  assign in_tmr = (state_q != TMR_INDEP);

  always_comb begin : proc_next_state
    state_d = state_q;

    case (state_q)
      TMR_INDEP: begin
        if (tmr_enable_we_i && tmr_enable_i) begin
          state_d = TMR_RUN;
        end
      end
      TMR_RUN: begin
        if (single_mismatch) begin
          state_d = TMR_RESYNCH;
        end
      end
      TMR_RESYNCH: begin
        if (tmr_cores_synch_i) begin
          state_d = TMR_RUN;
        end
      end
      default: begin
        state_d = TMR_INDEP;
      end
    endcase

    // Disabling wins over everything else
    if (tmr_enable_we_i && !tmr_enable_i) begin
      state_d = TMR_INDEP;
    end
  end

  always_ff @(posedge clk_i) begin : proc_state
    if (!rst_n_i) begin
      state_q   <= TMR_INDEP;
      setback_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // One cycle pulse in the first cycle of TMR
      setback_q <= (state_q == TMR_INDEP) && (state_d == TMR_RUN);
    end
  end

  // Mismatch counters

  // Only count while voting, hold the value in independent mode
  always_ff @(posedge clk_i) begin : proc_mismatch_cnt
    if (!rst_n_i) begin
      for (int i = 0; i < `HMR_GRP_SIZE; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (in_tmr) begin
      for (int i = 0; i < `HMR_GRP_SIZE; i++) begin
        if (error_cba[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + mismatch_cnt_t'(1);
        end
      end
    end
  end

  assign mismatch_cnt_o = cnt_q;

  // Outputs

  assign tmr_resynch_req_o = (state_q == TMR_RESYNCH);

  assign grp.in_tmr    = in_tmr;
  assign grp.voted     = voted;
  assign grp.failure   = failure;
  assign grp.error_cba = error_cba;
  assign grp.setback   = setback_q;

endmodule

// File: logic/hmr_unit.sv
/*
 * TMR wrapper top for six cores in two sequential groups of three:
 * input fan-out, one voting group per triple and output select
 */
`timescale 1ns/100ps
`include "hmr_params.svh"

module hmr_unit import hmr_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // Mode control, one bit per group, taken when the strobe is high
  input  logic [`HMR_NUM_GROUPS-1:0] tmr_enable_i,
  input  logic                       tmr_enable_we_i,
  input  logic [`HMR_NUM_GROUPS-1:0] tmr_cores_synch_i,

  // System side
  input  core_data_t                 sys_inputs_i   [`HMR_NUM_CORES],
  output core_data_t                 sys_outputs_o  [`HMR_NUM_CORES],

  // Core side
  input  core_data_t                 core_outputs_i [`HMR_NUM_CORES],
  output core_data_t                 core_inputs_o  [`HMR_NUM_CORES],
  output logic [`HMR_NUM_CORES-1:0]  core_setback_o,

  // Status
  output logic [`HMR_NUM_GROUPS-1:0] tmr_failure_o,
  output logic [`HMR_NUM_CORES-1:0]  tmr_error_o,
  output logic [`HMR_NUM_GROUPS-1:0] tmr_resynch_req_o,
  output mismatch_cnt_t              mismatch_cnt_o [`HMR_NUM_CORES]
);

  // One bundle per group
  tmr_grp_if grp_if [`HMR_NUM_GROUPS] ();

  hmr_input_fanout i_input_fanout (
    .sys_inputs_i  ( sys_inputs_i  ),
    .grp           ( grp_if        ),
    .core_inputs_o ( core_inputs_o )
  );

  for (genvar g = 0; g < `HMR_NUM_GROUPS; g++) begin : gen_tmr_groups
    core_data_t    grp_core_outputs [`HMR_GRP_SIZE];
    mismatch_cnt_t grp_mismatch_cnt [`HMR_GRP_SIZE];

    // Slice out this group's cores
    for (genvar k = 0; k < `HMR_GRP_SIZE; k++) begin : gen_grp_cores
      assign grp_core_outputs[k]                   = core_outputs_i[g*`HMR_GRP_SIZE + k];
      assign mismatch_cnt_o[g*`HMR_GRP_SIZE + k]   = grp_mismatch_cnt[k];
    end

    hmr_tmr_group i_tmr_group (
      .clk_i             ( clk_i                ),
      .rst_n_i           ( rst_n_i              ),
      .tmr_enable_i      ( tmr_enable_i[g]      ),
      .tmr_enable_we_i   ( tmr_enable_we_i      ),
      .tmr_cores_synch_i ( tmr_cores_synch_i[g] ),
      .core_outputs_i    ( grp_core_outputs     ),
      .mismatch_cnt_o    ( grp_mismatch_cnt     ),
      .tmr_resynch_req_o ( tmr_resynch_req_o[g] ),
      .grp               ( grp_if[g]            )
    );
  end

  hmr_output_select i_output_select (
    .core_outputs_i ( core_outputs_i ),
    .grp            ( grp_if         ),
    .sys_outputs_o  ( sys_outputs_o  ),
    .tmr_failure_o  ( tmr_failure_o  ),
    .tmr_error_o    ( tmr_error_o    ),
    .core_setback_o ( core_setback_o )
  );

endmodule

// File: logic/tmr_grp_if.sv
/*
 * Per-group bundle of mode, voted word and error signals,
 * with views for the group, the input fan-out and the output select
 */
`timescale 1ns/100ps

interface tmr_grp_if import hmr_pkg::*; ();

  logic       in_tmr;
  core_data_t voted;
  logic       failure;
  grp_err_t   error_cba;
  logic       setback;

  // Producer side, one group module
  modport group (
    output in_tmr,
    output voted,
    output failure,
    output error_cba,
    output setback
  );

  // Input steering only needs the mode
  modport fanout (
    input in_tmr
  );

  modport select (
    input in_tmr,
    input voted,
    input failure,
    input error_cba,
    input setback
  );

endinterface

// File: src.f
+incdir+logic
logic/hmr_pkg.sv
logic/tmr_grp_if.sv
logic/hmr_input_fanout.sv
logic/hmr_tmr_group.sv
logic/hmr_output_select.sv
logic/hmr_unit.sv
tests/hmr_unit_tb.sv

// File: tests/hmr_unit_tb.sv
/*
 * Testbench for the TMR wrapper: clock, reset, seeded random stimulus,
 * cycle-based reference model, compare tasks, watchdog and report
 */
`timescale 1ns/100ps
`include "hmr_params.svh"

module hmr_unit_tb import hmr_pkg::*; ();

  localparam int ClkPeriod     = 4;
  localparam int ResetCycles   = 5;
  localparam int IndepCycles   = 20;
  localparam int EntryCycles   = 8;
  localparam int CorruptCycles = 20;
  localparam int ResynchRounds = 2;
  localparam int MaxHold       = 9;
  localparam int ThreeWayCycles = 6;
  localparam int LeaveCycles   = 10;
  localparam int WatchdogCycles = ResetCycles + IndepCycles + (1 + EntryCycles) +
                                  CorruptCycles + ResynchRounds * (4 + MaxHold) +
                                  ThreeWayCycles + (1 + LeaveCycles) + 50;

  logic                       clk;
  logic                       rst_n;
  logic [`HMR_NUM_GROUPS-1:0] tmr_enable;
  logic                       tmr_enable_we;
  logic [`HMR_NUM_GROUPS-1:0] tmr_cores_synch;
  core_data_t                 sys_inputs     [`HMR_NUM_CORES];
  core_data_t                 core_outputs   [`HMR_NUM_CORES];
  core_data_t                 sys_outputs_o  [`HMR_NUM_CORES];
  core_data_t                 core_inputs_o  [`HMR_NUM_CORES];
  logic [`HMR_NUM_CORES-1:0]  core_setback_o;
  logic [`HMR_NUM_GROUPS-1:0] tmr_failure_o;
  logic [`HMR_NUM_CORES-1:0]  tmr_error_o;
  logic [`HMR_NUM_GROUPS-1:0] tmr_resynch_req_o;
  mismatch_cnt_t              mismatch_cnt_o [`HMR_NUM_CORES];

  // Reference model state
  tmr_state_e    m_state   [`HMR_NUM_GROUPS];
  logic          m_setback [`HMR_NUM_GROUPS];
  mismatch_cnt_t m_cnt     [`HMR_NUM_CORES];
  core_data_t    exp_maj   [`HMR_NUM_GROUPS];
  logic          exp_fail  [`HMR_NUM_GROUPS];
  logic          exp_err   [`HMR_NUM_CORES];

  int n_checks;
  int n_errors;
  int n_tests;
  int n_failed;

  hmr_unit hmr_unit_i (
    .clk_i             ( clk               ),
    .rst_n_i           ( rst_n             ),
    .tmr_enable_i      ( tmr_enable        ),
    .tmr_enable_we_i   ( tmr_enable_we     ),
    .tmr_cores_synch_i ( tmr_cores_synch   ),
    .sys_inputs_i      ( sys_inputs        ),
    .sys_outputs_o     ( sys_outputs_o     ),
    .core_outputs_i    ( core_outputs      ),
    .core_inputs_o     ( core_inputs_o     ),
    .core_setback_o    ( core_setback_o    ),
    .tmr_failure_o     ( tmr_failure_o     ),
    .tmr_error_o       ( tmr_error_o       ),
    .tmr_resynch_req_o ( tmr_resynch_req_o ),
    .mismatch_cnt_o    ( mismatch_cnt_o    )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic compare_data(string name, int idx, core_data_t act, core_data_t exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s[%0d] is %h, expected %h", $time, name, idx, act, exp);
    end
  endtask

  task automatic compare_flag(string name, int idx, logic act, logic exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s[%0d] is %b, expected %b", $time, name, idx, act, exp);
    end
  endtask

  task automatic compare_count(string name, int idx, mismatch_cnt_t act, mismatch_cnt_t exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s[%0d] is %0d, expected %0d", $time, name, idx, act, exp);
    end
  endtask

  // Bitwise 2-of-3 vote by counting the ones in each bit position
  function automatic core_data_t majority_word(core_data_t a, core_data_t b, core_data_t c);
    core_data_t m;
    int         ones;
    for (int i = 0; i < `HMR_DATA_WIDTH; i++) begin
      ones = 0;
      if (a[i]) ones++;
      if (b[i]) ones++;
      if (c[i]) ones++;
      m[i] = (ones >= 2);
    end
    return m;
  endfunction

  task automatic evaluate_votes();
    int base;
    for (int g = 0; g < `HMR_NUM_GROUPS; g++) begin
      base = g * `HMR_GRP_SIZE;
      exp_maj[g] = majority_word(core_outputs[base], core_outputs[base+1],
                                 core_outputs[base+2]);
      exp_fail[g] = (core_outputs[base] != core_outputs[base+1]) &&
                    (core_outputs[base] != core_outputs[base+2]) &&
                    (core_outputs[base+1] != core_outputs[base+2]);
      for (int k = 0; k < `HMR_GRP_SIZE; k++) begin
        exp_err[base+k] = (core_outputs[base+k] != exp_maj[g]);
      end
    end
  endtask

  task automatic verify_outputs();
    int         g;
    int         ofs;
    logic       tmr_now;
    core_data_t exp_out;
    evaluate_votes();
    for (int gi = 0; gi < `HMR_NUM_GROUPS; gi++) begin
      tmr_now = (m_state[gi] != TMR_INDEP);
      compare_flag("tmr_failure_o", gi, tmr_failure_o[gi], tmr_now && exp_fail[gi]);
      compare_flag("tmr_resynch_req_o", gi, tmr_resynch_req_o[gi], m_state[gi] == TMR_RESYNCH);
    end
    for (int c = 0; c < `HMR_NUM_CORES; c++) begin
      g = c / `HMR_GRP_SIZE;
      ofs = c % `HMR_GRP_SIZE;
      tmr_now = (m_state[g] != TMR_INDEP);
      compare_data("core_inputs_o", c, core_inputs_o[c],
                   tmr_now ? sys_inputs[g * `HMR_GRP_SIZE] : sys_inputs[c]);
      if (!tmr_now) begin
        exp_out = core_outputs[c];
      end else if (ofs == 0) begin
        exp_out = exp_maj[g];
      end else begin
        exp_out = '0;
      end
      compare_data("sys_outputs_o", c, sys_outputs_o[c], exp_out);
      compare_flag("tmr_error_o", c, tmr_error_o[c], tmr_now && exp_err[c]);
      compare_flag("core_setback_o", c, core_setback_o[c], (ofs != 0) && m_setback[g]);
      compare_count("mismatch_cnt_o", c, mismatch_cnt_o[c], m_cnt[c]);
    end
  endtask

  // Model update at a rising edge, from the inputs the DUT samples there
  task automatic apply_edge();
    tmr_state_e nxt;
    logic       tmr_now;
    logic       any_err;
    int         c;
    evaluate_votes();
    for (int g = 0; g < `HMR_NUM_GROUPS; g++) begin
      tmr_now = (m_state[g] != TMR_INDEP);
      any_err = 1'b0;
      for (int k = 0; k < `HMR_GRP_SIZE; k++) begin
        c = g * `HMR_GRP_SIZE + k;
        any_err = any_err | exp_err[c];
        if (tmr_now && exp_err[c] && (m_cnt[c] != '1)) begin
          m_cnt[c] = m_cnt[c] + mismatch_cnt_t'(1);
        end
      end
      nxt = m_state[g];
      if (tmr_enable_we && !tmr_enable[g]) begin
        nxt = TMR_INDEP;
      end else if (m_state[g] == TMR_INDEP && tmr_enable_we && tmr_enable[g]) begin
        nxt = TMR_RUN;
      end else if (m_state[g] == TMR_RUN && any_err && !exp_fail[g]) begin
        nxt = TMR_RESYNCH;
      end else if (m_state[g] == TMR_RESYNCH && tmr_cores_synch[g]) begin
        nxt = TMR_RUN;
      end
      m_setback[g] = (m_state[g] == TMR_INDEP) && (nxt == TMR_RUN);
      m_state[g] = nxt;
    end
  endtask

  // Check mid-cycle, follow the edge, then leave time for the next drive
  task automatic run_cycle();
    @(negedge clk);
    verify_outputs();
    @(posedge clk);
    apply_edge();
    #1;
  endtask

  task automatic drive_random_words();
    for (int c = 0; c < `HMR_NUM_CORES; c++) begin
      sys_inputs[c] = $urandom();
      core_outputs[c] = $urandom();
    end
  endtask

  task automatic drive_agreeing_words();
    core_data_t w;
    for (int g = 0; g < `HMR_NUM_GROUPS; g++) begin
      w = $urandom();
      for (int k = 0; k < `HMR_GRP_SIZE; k++) begin
        sys_inputs[g * `HMR_GRP_SIZE + k] = $urandom();
        core_outputs[g * `HMR_GRP_SIZE + k] = w;
      end
    end
  endtask

  // Flip a nonzero random mask into one core word
  task automatic corrupt_core(int idx);
    core_data_t flip;
    flip = $urandom();
    if (flip == '0) flip = core_data_t'(1);
    core_outputs[idx] = core_outputs[idx] ^ flip;
  endtask

  task automatic end_test(string name, int start_errors);
    n_tests++;
    if (n_errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      n_failed++;
      $display("test %s: failed with %0d errors", name, n_errors - start_errors);
    end
  endtask

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    int            start_errors;
    int            grp_sel;
    int            core_sel;
    int            hold;
    core_data_t    m1;
    core_data_t    m2;
    mismatch_cnt_t saved_cnt [`HMR_NUM_CORES];

    void'($urandom(32'hfeb1_5e14));
    n_checks = 0;
    n_errors = 0;
    n_tests  = 0;
    n_failed = 0;
    rst_n = 1'b0;
    tmr_enable = '0;
    tmr_enable_we = 1'b0;
    tmr_cores_synch = '0;
    for (int c = 0; c < `HMR_NUM_CORES; c++) begin
      sys_inputs[c] = '0;
      core_outputs[c] = '0;
      m_cnt[c] = '0;
    end
    for (int g = 0; g < `HMR_NUM_GROUPS; g++) begin
      m_state[g] = TMR_INDEP;
      m_setback[g] = 1'b0;
    end
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_errors = n_errors;
    repeat (IndepCycles) begin
      drive_random_words();
      run_cycle();
    end
    end_test("independent passthrough", start_errors);

    // Both groups enter TMR with agreeing cores
    start_errors = n_errors;
    drive_agreeing_words();
    tmr_enable = '1;
    tmr_enable_we = 1'b1;
    run_cycle();
    tmr_enable_we = 1'b0;
    repeat (EntryCycles) begin
      drive_agreeing_words();
      run_cycle();
    end
    end_test("TMR entry and setback", start_errors);

    start_errors = n_errors;
    grp_sel = $urandom_range(`HMR_NUM_GROUPS - 1, 0);
    core_sel = $urandom_range(`HMR_GRP_SIZE - 1, 0);
    repeat (CorruptCycles) begin
      drive_agreeing_words();
      corrupt_core(grp_sel * `HMR_GRP_SIZE + core_sel);
      run_cycle();
    end
    end_test("single core corruption", start_errors);

    start_errors = n_errors;
    repeat (ResynchRounds) begin
      // Start from TMR_RUN in both groups
      drive_agreeing_words();
      tmr_cores_synch = '1;
      run_cycle();
      tmr_cores_synch = '0;
      drive_agreeing_words();
      for (int g = 0; g < `HMR_NUM_GROUPS; g++) begin
        corrupt_core(g * `HMR_GRP_SIZE + $urandom_range(`HMR_GRP_SIZE - 1, 0));
      end
      run_cycle();
      hold = $urandom_range(MaxHold, 2);
      repeat (hold) begin
        drive_agreeing_words();
        run_cycle();
      end
      drive_agreeing_words();
      tmr_cores_synch = '1;
      run_cycle();
      tmr_cores_synch = '0;
      drive_agreeing_words();
      run_cycle();
    end
    end_test("resynch request", start_errors);

    start_errors = n_errors;
    grp_sel = $urandom_range(`HMR_NUM_GROUPS - 1, 0);
    repeat (ThreeWayCycles) begin
      drive_agreeing_words();
      m1 = $urandom();
      if (m1 == '0) m1 = core_data_t'(1);
      do begin
        m2 = $urandom();
      end while (m2 == '0 || m2 == m1);
      core_outputs[grp_sel * `HMR_GRP_SIZE + 1] = core_outputs[grp_sel * `HMR_GRP_SIZE] ^ m1;
      core_outputs[grp_sel * `HMR_GRP_SIZE + 2] = core_outputs[grp_sel * `HMR_GRP_SIZE] ^ m2;
      run_cycle();
    end
    end_test("three-way disagreement", start_errors);

    start_errors = n_errors;
    drive_agreeing_words();
    tmr_enable = '0;
    tmr_enable_we = 1'b1;
    run_cycle();
    tmr_enable_we = 1'b0;
    saved_cnt = m_cnt;
    repeat (LeaveCycles) begin
      drive_random_words();
      run_cycle();
    end
    // Counters must still hold the values from the last TMR cycle
    for (int c = 0; c < `HMR_NUM_CORES; c++) begin
      compare_count("mismatch_cnt_o", c, mismatch_cnt_o[c], saved_cnt[c]);
    end
    end_test("leaving TMR", start_errors);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
